// File: common/dc_pkg.sv
`default_nettype none

package dc_pkg;

   localparam int data_w   = 16;
   localparam int num_regs = 16;

   typedef logic [data_w-1:0] word_t;
   typedef logic [3:0]        reg_sel_t;
   typedef logic [1:0]        mode_t;
   typedef logic [3:0]        op_t;
   typedef logic [2:0]        cond_t;

   localparam reg_sel_t sp_reg  = 4'd6;   // stack pointer as seen by the microcode
   localparam reg_sel_t psw_reg = 4'd8;
   localparam reg_sel_t sp_alt1 = 4'd12;  // mode 01 copy of the SP
   localparam reg_sel_t sp_alt3 = 4'd13;  // mode 11 copy of the SP

   localparam mode_t mode_kernel = 2'b00;
   localparam mode_t mode_super  = 2'b01;
   localparam mode_t mode_user   = 2'b11;

   localparam op_t op_add = 4'd0;
   localparam op_t op_adc = 4'd1;
   localparam op_t op_sub = 4'd2;
   localparam op_t op_and = 4'd3;
   localparam op_t op_or  = 4'd4;
   localparam op_t op_xor = 4'd5;
   localparam op_t op_mov = 4'd6;   // A <= B
   localparam op_t op_ldi = 4'd7;   // A <= data_in
   localparam op_t op_brt = 4'd8;

   localparam cond_t cond_n    = 3'b000;
   localparam cond_t cond_z    = 3'b001;
   localparam cond_t cond_c    = 3'b010;
   localparam cond_t cond_v    = 3'b011;
   localparam cond_t cond_nn   = 3'b100;
   localparam cond_t cond_nz   = 3'b101;
   localparam cond_t cond_nc   = 3'b110;
   localparam cond_t cond_kern = 3'b111;

   // b is operand B, d is operand A
   typedef struct packed {
      logic gen_bnd;
      logic gen_nbd;
      logic gen_bd;
      logic prop_nn;
      logic prop_bd;
      logic prop_bnd;
      logic prop_nbd;
   } alu_ctl_t;

   // same order as PSW bits 3:0
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } flag_bits_t;

   localparam word_t psw_reset = '0;

endpackage

`default_nettype wire

// File: logic/micro_decode.sv
`timescale 1ns/1ns
`default_nettype none

module micro_decode import dc_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     m_valid,
   input  word_t    m_word,
   output reg_sel_t sel_a,
   output reg_sel_t sel_b,
   output logic     imm_sel,
   output logic     wr_en,
   output reg_sel_t wr_sel,
   output alu_ctl_t alu_ctl,
   output logic     carry_in_sel,
   output logic     sub,
   output logic     flag_en,
   output logic     logic_op,
   output logic     brt,
   output cond_t    cond,
   output logic     s2_valid
);

   op_t      op;
   alu_ctl_t ctl;
   logic     is_write;   // ALU ops, mov and ldi
   logic     is_arith;
   logic     is_logic;

   assign op      = m_word[15:12];
   assign sel_a   = m_word[3:0];    // read address goes straight to the register file
   assign sel_b   = m_word[7:4];
   assign imm_sel = m_valid && (op == op_ldi);

   assign is_write = (op <= op_ldi);
   assign is_arith = (op == op_add) || (op == op_adc) || (op == op_sub);
   assign is_logic = (op == op_and) || (op == op_or) || (op == op_xor);

   // minterm enables per opcode
   always_comb
   begin
      ctl = '0;
      case (op)
         op_add, op_adc:
         begin
            ctl.gen_bd   = 1'b1;
            ctl.prop_bnd = 1'b1;
            ctl.prop_nbd = 1'b1;
         end
         op_sub:
         begin
            ctl.gen_nbd = 1'b1;   // A + ~B
            ctl.prop_nn = 1'b1;
            ctl.prop_bd = 1'b1;
         end
         op_and:
            ctl.prop_bd = 1'b1;
         op_or:
         begin
            ctl.prop_bd  = 1'b1;
            ctl.prop_bnd = 1'b1;
            ctl.prop_nbd = 1'b1;
         end
         op_xor:
         begin
            ctl.prop_bnd = 1'b1;
            ctl.prop_nbd = 1'b1;
         end
         op_mov, op_ldi:
         begin
            ctl.prop_bd  = 1'b1;   // passes B through
            ctl.prop_bnd = 1'b1;
         end
         default:
            ctl = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         s2_valid     <= 1'b0;
         wr_en        <= 1'b0;
         wr_sel       <= '0;
         flag_en      <= 1'b0;
         brt          <= 1'b0;
         alu_ctl      <= '0;
         carry_in_sel <= 1'b0;
         sub          <= 1'b0;
         logic_op     <= 1'b0;
         cond         <= '0;
      end
      else
      begin
         s2_valid     <= m_valid;
         wr_en        <= m_valid && is_write;
         wr_sel       <= m_word[3:0];
         flag_en      <= m_valid && (is_arith || is_logic);
         brt          <= m_valid && (op == op_brt);
         alu_ctl      <= m_valid ? ctl : '0;   // idle and no-op give a zero sum
         carry_in_sel <= m_valid && (op == op_adc);
         sub          <= m_valid && (op == op_sub);
         logic_op     <= is_logic;
         cond         <= m_word[10:8];
      end
   end

endmodule

`default_nettype wire

// File: datapath/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import dc_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  reg_sel_t   sel_a,
   input  reg_sel_t   sel_b,
   input  logic       imm_sel,
   input  word_t      data_in,
   input  logic       wr_en,
   input  reg_sel_t   wr_sel,
   input  word_t      wr_data,
   input  logic       flag_we,
   input  flag_bits_t new_flags,
   output word_t      opa,
   output word_t      opb,
   output word_t      psw
);

   word_t    regs [num_regs];
   mode_t    mode;
   reg_sel_t wr_phys;
   logic     wr_hit;        // word write after bank mapping
   logic     flag_hit;
   word_t    psw_flagged;   // PSW with this cycle's flags merged in

   // register 6 is banked by the current mode
   function automatic reg_sel_t bank_map(reg_sel_t sel, mode_t m);
      reg_sel_t phys;
      phys = sel;
      if (sel == sp_reg)
      begin
         case (m)
            mode_super: phys = sp_alt1;
            mode_user:  phys = sp_alt3;
            default:    phys = sp_reg;
         endcase
      end
      return phys;
   endfunction

   // SP copies are only reachable through index 6
   function automatic logic is_shadow(reg_sel_t sel);
      return (sel == sp_alt1) || (sel == sp_alt3);
   endfunction

   function automatic word_t read_port(reg_sel_t sel);
      reg_sel_t phys;
      phys = bank_map(sel, mode);
      if (is_shadow(sel))
         return '0;
      else if (wr_hit && (phys == wr_phys))
         return wr_data;   // forward the write of this edge
      else if (flag_hit && (phys == psw_reg))
         return psw_flagged;
      else
         return regs[phys];
   endfunction

   assign psw  = regs[psw_reg];
   assign mode = psw[15:14];

   assign wr_phys     = bank_map(wr_sel, mode);
   assign wr_hit      = wr_en && !is_shadow(wr_sel);
   assign flag_hit    = flag_we && !(wr_en && (wr_sel == psw_reg));   // data write wins
   assign psw_flagged = {psw[data_w-1:4], new_flags};

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < num_regs; i++)
            regs[i] <= '0;
         regs[psw_reg] <= psw_reset;
         opa           <= '0;
         opb           <= '0;
      end
      else
      begin
         if (wr_hit)
            regs[wr_phys] <= wr_data;
         if (flag_hit)
            regs[psw_reg][3:0] <= new_flags;
         opa <= read_port(sel_a);
         opb <= imm_sel ? data_in : read_port(sel_b);
      end
   end

endmodule

`default_nettype wire

// File: datapath/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import dc_pkg::*;
(
   input  word_t    opa,
   input  word_t    opb,
   input  alu_ctl_t alu_ctl,
   input  logic     carry_in_sel,
   input  logic     sub,
   input  logic     psw_c,
   output word_t    sum,
   output logic     cout15,
   output logic     cout16
);

   word_t           g;   // per-bit generate
   word_t           p;   // per-bit propagate
   logic [data_w:0] c;   // carry into each bit

   always_comb
   begin
      for (int i = 0; i < data_w; i++)
      begin
         g[i] =  opb[i] & ~opa[i] & alu_ctl.gen_bnd
               | ~opb[i] &  opa[i] & alu_ctl.gen_nbd
               |  opb[i] &  opa[i] & alu_ctl.gen_bd;

         p[i] = ~opb[i] & ~opa[i] & alu_ctl.prop_nn
               |  opb[i] &  opa[i] & alu_ctl.prop_bd
               |  opb[i] & ~opa[i] & alu_ctl.prop_bnd
               | ~opb[i] &  opa[i] & alu_ctl.prop_nbd;
      end
   end

   assign c[0] = carry_in_sel ? psw_c : sub;   // adc takes C, sub takes 1

   // full look-ahead inside a tetrade, ripple between tetrades
   for (genvar t = 0; t < data_w; t += 4)
   begin : gen_tetrade
      assign c[t+1] = g[t]
                    | p[t] & c[t];
      assign c[t+2] = g[t+1]
                    | p[t+1] & g[t]
                    | p[t+1] & p[t] & c[t];
      assign c[t+3] = g[t+2]
                    | p[t+2] & g[t+1]
                    | p[t+2] & p[t+1] & g[t]
                    | p[t+2] & p[t+1] & p[t] & c[t];
      assign c[t+4] = g[t+3]
                    | p[t+3] & g[t+2]
                    | p[t+3] & p[t+2] & g[t+1]
                    | p[t+3] & p[t+2] & p[t+1] & g[t]
                    | p[t+3] & p[t+2] & p[t+1] & p[t] & c[t];
   end

   assign sum    = p ^ c[data_w-1:0];
   assign cout15 = c[data_w-1];   // carry into the sign bit
   assign cout16 = c[data_w];

endmodule

`default_nettype wire

// File: logic/flag_unit.sv
`timescale 1ns/1ns
`default_nettype none

module flag_unit import dc_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       s2_valid,
   input  word_t      sum,
   input  logic       cout15,
   input  logic       cout16,
   input  logic       sub,
   input  logic       flag_en,
   input  logic       logic_op,
   input  logic       brt,
   input  cond_t      cond,
   input  word_t      psw,
   output flag_bits_t new_flags,
   output logic       flag_we,
   output word_t      result,
   output logic       branch,
   output logic       result_valid
);

   flag_bits_t cur;       // flags as registered in the PSW
   mode_t      mode;
   logic       cond_hit;

   assign cur  = psw[3:0];
   assign mode = psw[15:14];

   always_comb
   begin
      new_flags.n = sum[data_w-1];
      new_flags.z = (sum == '0);
      if (logic_op)
      begin
         new_flags.v = 1'b0;
         new_flags.c = cur.c;   // logic ops keep C
      end
      else
      begin
         new_flags.v = cout15 ^ cout16;
         new_flags.c = sub ? ~cout16 : cout16;   // borrow for sub
      end
   end

   assign flag_we = s2_valid && flag_en;

   always_comb
   begin
      case (cond)
         cond_n:    cond_hit = cur.n;
         cond_z:    cond_hit = cur.z;
         cond_c:    cond_hit = cur.c;
         cond_v:    cond_hit = cur.v;
         cond_nn:   cond_hit = ~cur.n;
         cond_nz:   cond_hit = ~cur.z;
         cond_nc:   cond_hit = ~cur.c;
         default:   cond_hit = (mode == mode_kernel);
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         result_valid <= 1'b0;
         result       <= '0;
         branch       <= 1'b0;
      end
      else
      begin
         result_valid <= s2_valid;
         result       <= (s2_valid && !brt) ? sum : '0;
         branch       <= s2_valid && brt && cond_hit;
      end
   end

endmodule

`default_nettype wire

// File: logic/dc_core.sv
`timescale 1ns/1ns
`default_nettype none

module dc_core import dc_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  m_valid,
   input  word_t m_word,
   input  word_t data_in,
   output logic  result_valid,
   output word_t result,
   output logic  branch,
   output word_t psw
);

   reg_sel_t   sel_a;
   reg_sel_t   sel_b;
   logic       imm_sel;
   logic       wr_en;
   reg_sel_t   wr_sel;
   alu_ctl_t   alu_ctl;
   logic       carry_in_sel;
   logic       sub;
   logic       flag_en;
   logic       logic_op;
   logic       brt;
   cond_t      cond;
   logic       s2_valid;
   word_t      opa;
   word_t      opb;
   word_t      sum;
   logic       cout15;
   logic       cout16;
   flag_bits_t new_flags;
   logic       flag_we;

   micro_decode decode_i (
      .clk(clk), .rst(rst), .m_valid(m_valid), .m_word(m_word),
      .sel_a(sel_a), .sel_b(sel_b), .imm_sel(imm_sel),
      .wr_en(wr_en), .wr_sel(wr_sel), .alu_ctl(alu_ctl),
      .carry_in_sel(carry_in_sel), .sub(sub), .flag_en(flag_en),
      .logic_op(logic_op), .brt(brt), .cond(cond), .s2_valid(s2_valid)
   );

   reg_file regs_i (
      .clk(clk), .rst(rst), .sel_a(sel_a), .sel_b(sel_b), .imm_sel(imm_sel),
      .data_in(data_in), .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(sum),
      .flag_we(flag_we), .new_flags(new_flags),
      .opa(opa), .opb(opb), .psw(psw)
   );

   alu alu_i (
      .opa(opa), .opb(opb), .alu_ctl(alu_ctl), .carry_in_sel(carry_in_sel),
      .sub(sub), .psw_c(psw[0]),   // C flag feeds adc
      .sum(sum), .cout15(cout15), .cout16(cout16)
   );

   flag_unit flags_i (
      .clk(clk), .rst(rst), .s2_valid(s2_valid), .sum(sum),
      .cout15(cout15), .cout16(cout16), .sub(sub), .flag_en(flag_en),
      .logic_op(logic_op), .brt(brt), .cond(cond), .psw(psw),
      .new_flags(new_flags), .flag_we(flag_we), .result(result),
      .branch(branch), .result_valid(result_valid)
   );

endmodule

`default_nettype wire

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns of add_item: name, microword, data_in, expected result, expected branch
// add_idle fills a cycle with m_valid low and random data on data_in

function automatic word_t mw(op_t op, reg_sel_t a, reg_sel_t b, cond_t cd);
   return {op, 1'b0, cd, b, a};   // bit 11 unused
endfunction

function automatic word_t rand_word();
   int r;
   r = $random(seed);
   return r[15:0];
endfunction

task automatic add_item(input string name, input word_t word, input word_t din,
                        input word_t res, input logic br);
   tv_name[n_entries]   = name;
   tv_valid[n_entries]  = 1'b1;
   tv_word[n_entries]   = word;
   tv_data[n_entries]   = din;
   tv_result[n_entries] = res;
   tv_branch[n_entries] = br;
   n_entries++;
endtask

task automatic add_idle(input string name);
   tv_name[n_entries]   = name;
   tv_valid[n_entries]  = 1'b0;
   tv_word[n_entries]   = '0;
   tv_data[n_entries]   = rand_word();
   tv_result[n_entries] = '0;
   tv_branch[n_entries] = 1'b0;
   n_entries++;
endtask

task automatic build_table();
   word_t ra;
   word_t rb;
   word_t rc;
   word_t rd;
   word_t s_add;
   word_t s_adc;
   logic  c_add;
   logic  c_adc;
   logic  c_sub;
   ra = rand_word();
   rb = rand_word();
   rc = rand_word();
   rd = rand_word();
   {c_add, s_add} = ra + rb;
   {c_adc, s_adc} = ra + rb + c_add;
   c_sub = (rb > rc);   // borrow
   n_entries = 0;
   add_item("ldi r1", mw(op_ldi, 1, 0, 0), ra, ra, 0);
   add_item("ldi r2", mw(op_ldi, 2, 0, 0), rb, rb, 0);
   add_item("mov r3 fwd", mw(op_mov, 3, 2, 0), rand_word(), rb, 0);
   add_item("mov r4", mw(op_mov, 4, 1, 0), 0, ra, 0);
   add_item("add", mw(op_add, 4, 3, 0), 0, s_add, 0);
   add_item("brt c add", mw(op_brt, 0, 0, cond_c), 0, 0, c_add);
   add_item("brt nc add", mw(op_brt, 0, 0, cond_nc), 0, 0, !c_add);
   add_item("adc", mw(op_adc, 1, 2, 0), 0, s_adc, 0);
   add_item("brt c adc", mw(op_brt, 0, 0, cond_c), 0, 0, c_adc);
   add_item("ldi r5", mw(op_ldi, 5, 0, 0), rc, rc, 0);
   add_item("sub fwd", mw(op_sub, 5, 2, 0), 0, rc - rb, 0);
   add_item("brt c sub", mw(op_brt, 0, 0, cond_c), 0, 0, c_sub);
   add_item("brt nc sub", mw(op_brt, 0, 0, cond_nc), 0, 0, !c_sub);
   add_item("ldi r7", mw(op_ldi, 7, 0, 0), 16'hf00f, 16'hf00f, 0);
   add_item("sub borrow", mw(op_sub, 15, 7, 0), 0, 16'h0ff1, 0);   // sets C before logic ops
   add_item("ldi r9", mw(op_ldi, 9, 0, 0), 16'h0ff0, 16'h0ff0, 0);
   add_item("and", mw(op_and, 7, 9, 0), 0, 16'h0000, 0);
   add_item("brt z and", mw(op_brt, 0, 0, cond_z), 0, 0, 1);
   add_item("brt c kept", mw(op_brt, 0, 0, cond_c), 0, 0, 1);
   add_item("ldi r10", mw(op_ldi, 10, 0, 0), 16'h8001, 16'h8001, 0);
   add_item("or", mw(op_or, 10, 9, 0), 0, 16'h8ff1, 0);
   add_item("brt n or", mw(op_brt, 0, 0, cond_n), 0, 0, 1);
   add_item("brt nz or", mw(op_brt, 0, 0, cond_nz), 0, 0, 1);
   add_item("xor", mw(op_xor, 10, 9, 0), 0, 16'h8001, 0);
   add_item("brt nn xor", mw(op_brt, 0, 0, cond_nn), 0, 0, 0);
   add_item("brt c xor", mw(op_brt, 0, 0, cond_c), 0, 0, 1);
   add_idle("idle");
   add_item("ldi r11", mw(op_ldi, 11, 0, 0), 16'h7fff, 16'h7fff, 0);
   add_item("ldi r14", mw(op_ldi, 14, 0, 0), 16'h0001, 16'h0001, 0);
   add_item("add ovf", mw(op_add, 11, 14, 0), 0, 16'h8000, 0);
   add_item("brt v ovf", mw(op_brt, 0, 0, cond_v), 0, 0, 1);
   add_item("brt nc ovf", mw(op_brt, 0, 0, cond_nc), 0, 0, 1);
   add_item("nop", mw(4'd9, 1, 2, 0), rand_word(), 0, 0);
   add_item("ldi sp kern", mw(op_ldi, sp_reg, 0, 0), rd, rd, 0);
   add_item("ldi psw m1", mw(op_ldi, psw_reg, 0, 0), 16'h4000, 16'h4000, 0);
   add_idle("idle m1");
   add_item("brt kern m1", mw(op_brt, 0, 0, cond_kern), 0, 0, 0);
   add_item("ldi sp m1", mw(op_ldi, sp_reg, 0, 0), 16'h1234, 16'h1234, 0);
   add_item("mov sp m1", mw(op_mov, 15, sp_reg, 0), 0, 16'h1234, 0);
   add_item("mov r12", mw(op_mov, 15, sp_alt1, 0), 0, 16'h0000, 0);
   add_item("ldi psw m3", mw(op_ldi, psw_reg, 0, 0), 16'hc000, 16'hc000, 0);
   add_idle("idle m3");
   add_item("mov sp m3", mw(op_mov, 15, sp_reg, 0), 0, 16'h0000, 0);
   add_item("brt kern m3", mw(op_brt, 0, 0, cond_kern), 0, 0, 0);
   add_item("ldi psw m0", mw(op_ldi, psw_reg, 0, 0), 16'h0000, 16'h0000, 0);
   add_idle("idle m0");
   add_item("mov sp kern", mw(op_mov, 15, sp_reg, 0), 0, rd, 0);
   add_item("brt kern m0", mw(op_brt, 0, 0, cond_kern), 0, 0, 1);
endtask

`endif

// File: tests/tb_dc_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dc_core import dc_pkg::*;
();

   localparam int tbl_depth  = 64;
   localparam int clk_period = 10;

   logic  clk;
   logic  rst;
   logic  m_valid;
   word_t m_word;
   word_t data_in;
   logic  result_valid;
   word_t result;
   logic  branch;
   word_t psw;

   string tv_name   [tbl_depth];
   logic  tv_valid  [tbl_depth];   // low for an idle cycle
   word_t tv_word   [tbl_depth];
   word_t tv_data   [tbl_depth];
   word_t tv_result [tbl_depth];
   logic  tv_branch [tbl_depth];
   int    n_entries;

   int seed = 56275;
   int cycle;
   int errors;
   int n_items;
   int n_passed;
   int n_failed;
   int pend_idx [$];   // items in flight
   int pend_due [$];   // cycle in which each result is due

   `include "tb_vectors.svh"

   dc_core dut_i (
      .clk(clk), .rst(rst), .m_valid(m_valid), .m_word(m_word), .data_in(data_in),
      .result_valid(result_valid), .result(result), .branch(branch), .psw(psw)
   );

   always #(clk_period / 2) clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic record_item(input int idx, input bit ok);
      $display("%s %s", ok ? "ok  " : "FAIL", tv_name[idx]);
      if (ok)
         n_passed++;
      else
         n_failed++;
   endtask

   // outputs are registered, so they are stable at the falling edge
   always @(negedge clk)
   begin
      int idx;
      int due;
      int err_before;
      if (!rst)
      begin
         if (result_valid === 1'b1 && pend_idx.size() == 0)
         begin
            $display("result_valid high in cycle %0d with no item in flight", cycle);
            errors++;
         end
         else if (result_valid === 1'b1)
         begin
            idx = pend_idx.pop_front();
            due = pend_due.pop_front();
            err_before = errors;
            check({tv_name[idx], " latency"}, due, cycle);
            check({tv_name[idx], " result"}, tv_result[idx], result);
            check({tv_name[idx], " branch"}, tv_branch[idx], branch);
            // a load into register 8 shows up on psw at the same edge
            if (tv_word[idx][15:12] == op_ldi && tv_word[idx][3:0] == psw_reg)
               check({tv_name[idx], " psw"}, tv_result[idx], psw);
            record_item(idx, errors == err_before);
         end
         else if (result_valid !== 1'b0)
         begin
            $display("result_valid is unknown in cycle %0d", cycle);
            errors++;
         end
         else if (pend_due.size() > 0 && pend_due[0] <= cycle)
         begin
            idx = pend_idx.pop_front();
            due = pend_due.pop_front();
            $display("no result_valid for %s in cycle %0d", tv_name[idx], due);
            errors++;
            record_item(idx, 0);
         end
      end
   end

   initial
   begin
      #((tbl_depth + 20) * clk_period);
      $display("watchdog expired, results stopped arriving after %0d of %0d items",
               n_passed + n_failed, n_items);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      clk     = 1'b0;
      rst     = 1'b1;
      m_valid = 1'b0;
      m_word  = '0;
      data_in = '0;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      check("reset result_valid", 0, result_valid);
      for (int i = 0; i < n_entries; i++)
      begin
         m_valid = tv_valid[i];
         m_word  = tv_word[i];
         data_in = tv_data[i];
         if (tv_valid[i])
         begin
            pend_idx.push_back(i);
            pend_due.push_back(cycle + 2);   // sampled next edge, registered one later
            n_items++;
         end
         @(posedge clk);
         #1;
      end
      m_valid = 1'b0;
      m_word  = '0;
      data_in = '0;
      while (pend_idx.size() > 0)
         @(posedge clk);
      repeat (3) @(posedge clk);   // catch a stray result_valid
      $display("items %0d, passed %0d, failed %0d, errors %0d",
               n_items, n_passed, n_failed, errors);
      if (errors == 0 && n_passed == n_items)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
common/dc_pkg.sv
logic/micro_decode.sv
datapath/reg_file.sv
datapath/alu.sv
logic/flag_unit.sv
logic/dc_core.sv
tests/tb_dc_core.sv

// File: Bender.yml
package:
  name: dc_core

sources:
  - common/dc_pkg.sv
  - logic/micro_decode.sv
  - datapath/reg_file.sv
  - datapath/alu.sv
  - logic/flag_unit.sv
  - logic/dc_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dc_core.sv
